// File: fetch_pkg.sv
package fetch_pkg;

    // program counter and line geometry
    localparam int PC_W       = 64;              // full 64-bit pc
    localparam int LINE_BYTES = 16;              // one fetch line
    localparam int SLOTS      = 4;               // instructions per line
    localparam int LINE_W     = LINE_BYTES * 8;  // 128-bit line

    // derived pc fields
    localparam int OFFS_W  = $clog2(LINE_BYTES); // byte offset inside a line, pc[3:0]
    localparam int SLOT_W  = $clog2(SLOTS);      // slot select width
    localparam int SLOT_LO = 2;                  // slot select is pc[3:2]

    // defaults handed to fetch_top, overridable there
    localparam int MEM_LINES_DEF  = 64;          // instruction memory depth in lines
    localparam int IBUF_DEPTH_DEF = 4;           // line queue depth

    // fixed memory latency, accept edge to done, not a knob
    localparam int MEM_LAT = 2;

endpackage

// File: inst_pkg.sv
package inst_pkg;

    localparam int INST_W = 32;                  // one instruction word

    // opcode field sits in the top six bits
    localparam int OPC_HI = 31;
    localparam int OPC_LO = 26;
    localparam logic [OPC_HI-OPC_LO:0] OPC_JUMP = 6'h02;

    localparam int IMM_W = 26;                   // jump target field, inst[25:0]

    // opcode compare for a single word
    function automatic logic is_jump(input logic [INST_W-1:0] inst);
        return inst[OPC_HI:OPC_LO] == OPC_JUMP;
    endfunction

    // word target times four, caller zero extends to the pc width
    function automatic logic [IMM_W+1:0] jump_target(input logic [INST_W-1:0] inst);
        return {inst[IMM_W-1:0], 2'b00};
    endfunction

endpackage

// File: pc_ctrl.sv
`timescale 1ns/1ps

module pc_ctrl import fetch_pkg::*; (
    input  logic            clock,
    input  logic            reset_n,
    input  logic [PC_W-1:0] boot_addr,         // pc after reset
    input  logic            redirect_valid,    // back end override
    input  logic [PC_W-1:0] redirect_target,
    input  logic            fetch_inst,        // buffer level, room for another line
    input  logic            pc_index_ready,    // memory idle
    input  logic            pc_operation_done, // one-cycle response pulse
    input  logic            predict_taken,     // from predecode, valid with done
    input  logic [PC_W-1:0] predict_target,
    output logic            pc_index_valid,
    output logic [PC_W-1:0] pc_index
);

    logic [PC_W-1:0] pc;
    logic            pc_req_handshake;     // request accepted this cycle
    logic            pc_req_outstanding;   // accepted, waiting for done

    assign pc_req_handshake = pc_index_valid && pc_index_ready;

    // next pc: redirect beats prediction, prediction beats next line
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            pc <= boot_addr;
        end else if (redirect_valid) begin
            pc <= redirect_target;
        end else if (pc_operation_done && predict_taken) begin
            pc <= predict_target;
        end else if (pc_operation_done) begin
            pc <= {pc[PC_W-1:OFFS_W], OFFS_W'(0)} + PC_W'(LINE_BYTES); // align, step one line
        end
    end

    // one request in flight at a time
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            pc_req_outstanding <= 1'b0;
        end else if (redirect_valid) begin
            pc_req_outstanding <= 1'b0;    // response killed in fetch_mem too
        end else if (pc_req_handshake) begin
            pc_req_outstanding <= 1'b1;
        end else if (pc_operation_done) begin
            pc_req_outstanding <= 1'b0;
        end
    end

    // valid goes up one cycle after the pc settles, drops after the accept
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            pc_index_valid <= 1'b0;
        end else if (redirect_valid) begin
            pc_index_valid <= 1'b1;        // refetch from target right away
        end else if (fetch_inst && !pc_req_outstanding && !pc_req_handshake) begin
            pc_index_valid <= 1'b1;
        end else begin
            pc_index_valid <= 1'b0;
        end
    end

    assign pc_index = pc;

    // memory must only answer requests this block still waits on
    a_done_needs_outstanding: assert property (@(posedge clock) disable iff (!reset_n)
        pc_operation_done |-> pc_req_outstanding)
        else $error("pc_ctrl: done without an outstanding request");

endmodule

// File: fetch_mem.sv
`timescale 1ns/1ps

module fetch_mem import fetch_pkg::*; #(
    parameter int MEM_LINES = MEM_LINES_DEF
) (
    input  logic                         clock,
    input  logic                         reset_n,
    input  logic                         load_valid,        // preload write
    input  logic [$clog2(MEM_LINES)-1:0] load_index,
    input  logic [LINE_W-1:0]            load_line,
    input  logic                         pc_index_valid,
    input  logic [PC_W-1:0]              pc_index,
    input  logic                         redirect_valid,    // kills pending response
    output logic                         pc_index_ready,
    output logic                         pc_operation_done,
    output logic [PC_W-1:0]              resp_pc,
    output logic [LINE_W-1:0]            resp_line
);

    localparam int IDX_W = $clog2(MEM_LINES);

    logic [LINE_W-1:0]  mem [MEM_LINES];     // line storage
    logic [MEM_LAT-1:0] sh_v;                // request valid per stage
    logic [PC_W-1:0]    sh_pc [MEM_LAT];     // request pc per stage
    logic [LINE_W-1:0]  line_q;              // read data for the last stage
    logic               accept;
    logic [IDX_W-1:0]   rd_idx;

    assign pc_index_ready = (sh_v == '0);    // nothing pending
    assign accept         = pc_index_valid && pc_index_ready;

    // line index from the pc just ahead of the last stage
    assign rd_idx = sh_pc[MEM_LAT-2][OFFS_W +: IDX_W];

    always_ff @(posedge clock) begin
        if (load_valid) begin
            mem[load_index] <= load_line;
        end
    end

    // redirect flushes every stage of the valid shift and any new accept
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            sh_v <= '0;
        end else if (redirect_valid) begin
            sh_v <= '0;
        end else begin
            sh_v <= {sh_v[MEM_LAT-2:0], accept};
        end
    end

    // pc and read data follow the valid bits
    always_ff @(posedge clock) begin
        sh_pc[0] <= pc_index;
        for (int i = 1; i < MEM_LAT; i++) begin
            sh_pc[i] <= sh_pc[i-1];
        end
        line_q <= mem[rd_idx];               // read lands with the last stage
    end

    assign pc_operation_done = sh_v[MEM_LAT-1];  // one-cycle pulse MEM_LAT cycles after the accept
    assign resp_pc           = sh_pc[MEM_LAT-1];
    assign resp_line         = line_q;

    // pc_ctrl keeps a single request in flight
    a_no_accept_busy: assert property (@(posedge clock) disable iff (!reset_n)
        (sh_v != '0) |-> !pc_index_valid)
        else $error("fetch_mem: request offered while one is pending");

endmodule

// File: line_predecode.sv
`timescale 1ns/1ps

module line_predecode import fetch_pkg::*, inst_pkg::*; (
    input  logic [PC_W-1:0]   resp_pc,
    input  logic [LINE_W-1:0] resp_line,
    input  logic              pc_operation_done,
    output logic              predict_taken,
    output logic [PC_W-1:0]   predict_target
);

    logic [SLOT_W-1:0] start_slot;       // slot the pc points at
    logic [SLOTS-1:0]  hit;              // jump found in this slot
    logic [INST_W-1:0] words [SLOTS];    // line split into instructions

    assign start_slot = resp_pc[SLOT_LO +: SLOT_W];

    // slot 0 in the low word
    always_comb begin
        for (int i = 0; i < SLOTS; i++) begin
            words[i] = resp_line[i*INST_W +: INST_W];
        end
    end

    // words before the entry slot are not executed, skip them
    always_comb begin
        for (int i = 0; i < SLOTS; i++) begin
            hit[i] = (i >= int'(start_slot)) && is_jump(words[i]);
        end
    end

    // lowest hit wins, so scan from the top and let lower slots overwrite
    always_comb begin
        predict_target = '0;
        for (int i = SLOTS-1; i >= 0; i--) begin
            if (hit[i]) begin
                predict_target = PC_W'(jump_target(words[i]));  // zero extended
            end
        end
    end

    assign predict_taken = pc_operation_done && (hit != '0);    // only with a real response

endmodule

// File: inst_buffer.sv
`timescale 1ns/1ps

module inst_buffer import fetch_pkg::*; #(
    parameter int IBUF_DEPTH = IBUF_DEPTH_DEF
) (
    input  logic              clock,
    input  logic              reset_n,
    input  logic              redirect_valid,     // flush
    input  logic              pc_operation_done,  // push strobe
    input  logic [PC_W-1:0]   resp_pc,
    input  logic [LINE_W-1:0] resp_line,
    input  logic              predict_taken,
    input  logic              out_ready,
    output logic              fetch_inst,         // level back to pc_ctrl
    output logic              out_valid,
    output logic [PC_W-1:0]   out_pc,
    output logic [LINE_W-1:0] out_line,
    output logic              out_taken
);

    localparam int PTR_W = (IBUF_DEPTH > 1) ? $clog2(IBUF_DEPTH) : 1;
    localparam int CNT_W = $clog2(IBUF_DEPTH + 1);

    logic [PC_W-1:0]   pc_q    [IBUF_DEPTH];
    logic [LINE_W-1:0] line_q  [IBUF_DEPTH];
    logic              taken_q [IBUF_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              push;
    logic              pop;

    assign push = pc_operation_done && !redirect_valid;   // stale line dropped on redirect
    assign pop  = out_valid && out_ready && !redirect_valid;

    // keep one entry spare for the line still in fetch_mem
    assign fetch_inst = (count <= CNT_W'(IBUF_DEPTH - 2));

    // pointers wrap at the depth, works for any depth
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (redirect_valid) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(IBUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(IBUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);  // both at once leaves it alone
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            pc_q[wr_ptr]    <= resp_pc;
            line_q[wr_ptr]  <= resp_line;
            taken_q[wr_ptr] <= predict_taken;  // marks the line holding the jump
        end
    end

    assign out_valid = (count != '0);
    assign out_pc    = pc_q[rd_ptr];
    assign out_line  = line_q[rd_ptr];
    assign out_taken = taken_q[rd_ptr];

    // fetch_inst and the single outstanding request must keep the queue from overflowing
    a_no_push_full: assert property (@(posedge clock) disable iff (!reset_n)
        push |-> (count < CNT_W'(IBUF_DEPTH)))
        else $error("inst_buffer: push into a full queue");

endmodule

// File: fetch_top.sv
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; #(
    parameter int MEM_LINES  = MEM_LINES_DEF,
    parameter int IBUF_DEPTH = IBUF_DEPTH_DEF
) (
    input  logic                         clock,
    input  logic                         reset_n,
    input  logic [PC_W-1:0]              boot_addr,
    input  logic                         redirect_valid,
    input  logic [PC_W-1:0]              redirect_target,
    input  logic                         load_valid,
    input  logic [$clog2(MEM_LINES)-1:0] load_index,
    input  logic [LINE_W-1:0]            load_line,
    input  logic                         out_ready,
    output logic                         out_valid,
    output logic [PC_W-1:0]              out_pc,
    output logic [LINE_W-1:0]            out_line,
    output logic                         out_taken
);

    logic              pc_index_valid;     // pc_ctrl request
    logic [PC_W-1:0]   pc_index;
    logic              pc_index_ready;     // memory idle
    logic              pc_operation_done;  // response pulse
    logic [PC_W-1:0]   resp_pc;
    logic [LINE_W-1:0] resp_line;
    logic              predict_taken;      // same cycle as done
    logic [PC_W-1:0]   predict_target;
    logic              fetch_inst;         // buffer has room

    pc_ctrl u_pc_ctrl (.*);

    fetch_mem #(.MEM_LINES(MEM_LINES)) u_fetch_mem (.*);

    line_predecode u_line_predecode (.*);

    inst_buffer #(.IBUF_DEPTH(IBUF_DEPTH)) u_inst_buffer (.*);

endmodule

// File: tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch import fetch_pkg::*, inst_pkg::*; ();

    localparam int IDX_W    = $clog2(MEM_LINES_DEF);
    localparam int MAX_CMDS = 64;

    logic              clock;
    logic              reset_n;
    logic [PC_W-1:0]   boot_addr;
    logic              redirect_valid;
    logic [PC_W-1:0]   redirect_target;
    logic              load_valid;
    logic [IDX_W-1:0]  load_index;
    logic [LINE_W-1:0] load_line;
    logic              out_ready;
    logic              out_valid;
    logic [PC_W-1:0]   out_pc;
    logic [LINE_W-1:0] out_line;
    logic              out_taken;

    logic [7:0]        cmd_q [MAX_CMDS];       // command letter per entry
    int                num_q [MAX_CMDS];       // index, count or percent
    logic [LINE_W-1:0] val_q [MAX_CMDS];       // line or address
    int                n_cmds;
    logic [LINE_W-1:0] mdl_mem [MEM_LINES_DEF]; // model copy of the line memory
    logic [PC_W-1:0]   m_pc;                   // model pc, next line to come out
    int                ready_pct = 100;
    bit                started;
    int                err_value;
    int                err_other;
    int                lines_checked;
    int                cycle_count = 0;
    int                cycle_limit = 200;      // raised once the tests are read

    fetch_top UUT (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // hang guard
    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles, the fetch path hung", cycle_count);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic read_tests();
        int                fd;
        int                code;
        int                num;
        int                total;
        logic [7:0]        c;
        logic [LINE_W-1:0] val;
        logic [8*128-1:0]  rest;
        total  = 0;
        n_cmds = 0;
        fd = $fopen("fetch_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open fetch_tests.txt");
            err_other++;
            return;
        end
        while (n_cmds < MAX_CMDS) begin
            code = $fscanf(fd, " %c", c);
            if (code != 1) break;
            num = 0;
            val = '0;
            case (c)
                "#":      code = $fgets(rest, fd);   // comment, skip the rest of the line
                "L", "R": code = $fscanf(fd, " %d %h", num, val);
                "B":      code = $fscanf(fd, " %h", val);
                "D", "E": code = $fscanf(fd, " %d", num);
                default: begin
                    $display("unknown command %c in fetch_tests.txt", c);
                    err_other++;
                end
            endcase
            if (c inside {"L", "R", "B", "D", "E"}) begin
                cmd_q[n_cmds] = c;
                num_q[n_cmds] = num;
                val_q[n_cmds] = val;
                n_cmds++;
                if (c == "E" || c == "R") total += num;
            end
        end
        $fclose(fd);
        cycle_limit = 40 * total + 200;
    endtask

    // next expected line from the pc rule and the jump scan
    task automatic model_next(output logic [PC_W-1:0] e_pc, output logic [LINE_W-1:0] e_line,
                              output logic e_taken);
        logic [INST_W-1:0] word;
        logic              found;
        logic [PC_W-1:0]   target;
        e_pc   = m_pc;
        e_line = mdl_mem[m_pc[OFFS_W +: IDX_W]];
        found  = 1'b0;
        target = '0;
        for (int s = 0; s < SLOTS; s++) begin
            word = e_line[s*INST_W +: INST_W];
            if (!found && s >= int'(m_pc[3:2]) && word[31:26] == OPC_JUMP) begin
                found  = 1'b1;                          // first jump from the entry slot
                target = {36'd0, word[25:0], 2'b00};
            end
        end
        e_taken = found;
        m_pc = found ? target : {m_pc[PC_W-1:4], 4'h0} + 64'd16;
    endtask

    task automatic load_line_at(input int index, input logic [LINE_W-1:0] line);
        @(negedge clock);
        load_valid = 1'b1;
        load_index = IDX_W'(index);
        load_line  = line;
        mdl_mem[IDX_W'(index)] = line;
    endtask

    task automatic apply_reset();
        @(negedge clock);
        load_valid = 1'b0;
        reset_n    = 1'b0;
        repeat (2) @(negedge clock);
        if (out_valid !== 1'b0) begin
            $display("ERROR t=%0t out_valid expected 0 got %b", $time, out_valid);
            err_value++;
        end
        if (UUT.pc_index_valid !== 1'b0) begin
            $display("ERROR t=%0t pc_index_valid expected 0 got %b", $time, UUT.pc_index_valid);
            err_value++;
        end
        if (UUT.pc_index !== boot_addr) begin
            $display("ERROR t=%0t pc_index expected %h got %h", $time, boot_addr, UUT.pc_index);
            err_value++;
        end
        reset_n = 1'b1;
        m_pc    = boot_addr;
        started = 1'b1;
    endtask

    // a line is taken on the rising edge after ready and valid meet here
    task automatic consume_lines(input int n);
        int                got;
        logic [PC_W-1:0]   e_pc;
        logic [LINE_W-1:0] e_line;
        logic              e_taken;
        got = 0;
        while (got < n) begin
            @(negedge clock);
            out_ready = ($urandom % 100) < ready_pct;
            if (out_ready && out_valid) begin
                model_next(e_pc, e_line, e_taken);
                if (out_pc !== e_pc) begin
                    $display("ERROR t=%0t out_pc expected %h got %h", $time, e_pc, out_pc);
                    err_value++;
                end
                if (out_line !== e_line) begin
                    $display("ERROR t=%0t out_line expected %h got %h", $time, e_line, out_line);
                    err_value++;
                end
                if (out_taken !== e_taken) begin
                    $display("ERROR t=%0t out_taken expected %b got %b", $time, e_taken, out_taken);
                    err_value++;
                end
                got++;
                lines_checked++;
            end
        end
    endtask

    task automatic redirect_to(input logic [PC_W-1:0] target);
        @(negedge clock);
        out_ready       = 1'b0;               // nothing consumed during the flush
        redirect_valid  = 1'b1;
        redirect_target = target;
        @(negedge clock);
        redirect_valid  = 1'b0;
        m_pc            = target;             // unconsumed model lines are gone
    endtask

    initial begin
        reset_n         = 1'b1;               // memory is loaded before the reset pulse
        boot_addr       = '0;
        redirect_valid  = 1'b0;
        redirect_target = '0;
        load_valid      = 1'b0;
        load_index      = '0;
        load_line       = '0;
        out_ready       = 1'b0;
        err_value       = 0;
        err_other       = 0;
        lines_checked   = 0;
        started         = 1'b0;
        void'($urandom(58));
        read_tests();
        for (int k = 0; k < n_cmds; k++) begin
            case (cmd_q[k])
                "L": begin
                    if (started) begin
                        $display("memory load after fetch started, command %0d", k);
                        err_other++;
                    end else begin
                        load_line_at(num_q[k], val_q[k]);
                    end
                end
                "B": boot_addr = val_q[k][PC_W-1:0];
                "D": ready_pct = num_q[k];
                default: begin                 // E or R
                    if (!started) apply_reset();
                    consume_lines(num_q[k]);
                    if (cmd_q[k] == "R") redirect_to(val_q[k][PC_W-1:0]);
                end
            endcase
        end
        @(negedge clock);
        out_ready = 1'b0;
        if (lines_checked == 0) begin
            $display("no output line was checked");
            err_other++;
        end
        $display("%0d lines checked, %0d value errors, %0d other errors",
                 lines_checked, err_value, err_other);
        if (err_value == 0 && err_other == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: fetch_tests.txt
# L index line | B addr | D ready_percent | E count | R count addr (redirect after count lines)
# index and counts decimal, lines and addresses hex, slot 0 is the low word of a line
L 0 33333333222222221111111100000000
L 1 13131313121212121111111110101010
L 2 44444444080000205555555566666666
L 5 1234567808000030AAAAAAAA08000028
L 8 08000000777777778888888899999999
L 10 0123456789ABCDEF0123456712345678
L 11 FFFFFFFFEEEEEEEE0000000108000000
L 12 BBBBBBBBCCCCCCCC08000015DDDDDDDD
B 10
D 100
E 6
R 2 54
E 4
R 0 50
E 3
D 30
E 12
R 3 20
E 10

// File: src.f
fetch_pkg.sv
inst_pkg.sv
pc_ctrl.sv
fetch_mem.sv
line_predecode.sv
inst_buffer.sv
fetch_top.sv
tb_fetch.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_fetch
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= ** PASS **

SRCS := $(shell cat src.f)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: run clean

run: $(BIN) fetch_tests.txt
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_TEXT)'

$(BIN): $(SRCS) src.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f src.f --Mdir $(BUILD_DIR) -o V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
